//--- all.f
conv_cfg_pkg.sv
conv_mem_pkg.sv
mem_port_if.sv
feature_mem.sv
mem_arbiter.sv
row_fetcher.sv
row_buffers.sv
conv_datapath_front.sv
conv_dp_front_tb.sv

//--- conv_cfg_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Layer configuration and pixel types
////////////////////////////////////////////////////////////////////////////

package conv_cfg_pkg;

   // One feature map pixel
   typedef logic [7:0] pix_t;

   // Image coordinate or count
   // Signed so padded positions left of and above the image stay negative
   typedef logic signed [15:0] dim_t;

   // Stride or padding amount
   typedef logic [3:0] stride_t;

   // Log2 of the input width, input rows are a power of two wide
   typedef logic [3:0] log2_t;

endpackage : conv_cfg_pkg

`default_nettype wire

//--- conv_datapath_front.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Convolution datapath front end
// Host loads the feature map, en fetches three rows for output row oy
////////////////////////////////////////////////////////////////////////////

module conv_datapath_front #(
   parameter int PIXELS_IN_ROW = 8,
   parameter int MEM_ADDR_W    = 12
) (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    en,
   input  wire conv_cfg_pkg::dim_t      oy,
   input  wire conv_cfg_pkg::dim_t      iy,
   input  wire conv_cfg_pkg::dim_t      ox,
   input  wire conv_cfg_pkg::stride_t   s,
   input  wire conv_cfg_pkg::stride_t   p,
   input  wire conv_cfg_pkg::log2_t     ix_log2,
   // Host write strobe
   input  wire logic                    wr_en,
   input  wire conv_mem_pkg::mem_addr_t wr_addr,
   input  wire conv_cfg_pkg::pix_t      wr_data,
   output logic [PIXELS_IN_ROW*8-1:0]   re_row1_pixels,
   output logic [PIXELS_IN_ROW*8-1:0]   re_row2_pixels,
   output logic [PIXELS_IN_ROW*8-1:0]   re_row3_pixels,
   output logic                         done
);
   import conv_cfg_pkg::*;
   import conv_mem_pkg::*;

   localparam int COL_W = (PIXELS_IN_ROW > 1) ? $clog2(PIXELS_IN_ROW) : 1;

   // SRAM port
   logic      mem_en;
   logic      mem_we;
   mem_addr_t mem_addr;
   pix_t      mem_wdata;
   pix_t      mem_rdata;

   // Fetcher to staging buffers
   logic             pix_wr;
   logic [1:0]       pix_row;
   logic [COL_W-1:0] pix_col;
   pix_t             pix_data;
   logic             swap;

   // One port per requester
   mem_port_if port [2] ();

   // Host side is write only
   assign port[REQ_HOST].req   = wr_en;
   assign port[REQ_HOST].we    = 1'b1;
   assign port[REQ_HOST].addr  = wr_addr;
   assign port[REQ_HOST].wdata = wr_data;

   feature_mem #(
      .MEM_ADDR_W (MEM_ADDR_W)
   ) u_mem (
      .clk       (clk),
      .mem_en    (mem_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

   mem_arbiter u_arb (
      .clk       (clk),
      .rst       (rst),
      .host      (port[REQ_HOST]),
      .fetch     (port[REQ_FETCH]),
      .mem_en    (mem_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

   row_fetcher #(
      .PIXELS_IN_ROW (PIXELS_IN_ROW)
   ) u_fetch (
      .clk      (clk),
      .rst      (rst),
      .en       (en),
      .oy       (oy),
      .iy       (iy),
      .ox       (ox),
      .s        (s),
      .p        (p),
      .ix_log2  (ix_log2),
      .mem      (port[REQ_FETCH]),
      .pix_wr   (pix_wr),
      .pix_row  (pix_row),
      .pix_col  (pix_col),
      .pix_data (pix_data),
      .swap     (swap),
      .done     (done)
   );

   row_buffers #(
      .PIXELS_IN_ROW (PIXELS_IN_ROW)
   ) u_bufs (
      .clk            (clk),
      .rst            (rst),
      .pix_wr         (pix_wr),
      .pix_row        (pix_row),
      .pix_col        (pix_col),
      .pix_data       (pix_data),
      .swap           (swap),
      .re_row1_pixels (re_row1_pixels),
      .re_row2_pixels (re_row2_pixels),
      .re_row3_pixels (re_row3_pixels)
   );

endmodule : conv_datapath_front

`default_nettype wire

//--- conv_dp_front_tb.sv
`timescale 1ns/100ps
`default_nettype none

module conv_dp_front_tb;
   import conv_cfg_pkg::*;
   import conv_mem_pkg::*;

   localparam int PIXELS_IN_ROW = 8;
   localparam int MEM_ADDR_W    = 12;
   localparam int ROW_W         = PIXELS_IN_ROW * 8;
   localparam int MEM_WORDS     = 1 << MEM_ADDR_W;
   // Image 16 wide and 8 high inside a fully written memory
   localparam int IX_LOG2       = 4;
   localparam int IMG_W         = 1 << IX_LOG2;
   localparam int IMG_H         = 8;
   // Fetches over all tests
   // 50 cycles allowed per fetched pixel
   localparam int NUM_FETCHES    = 12;
   localparam int TIMEOUT_CYCLES = NUM_FETCHES * 3 * PIXELS_IN_ROW * 50;

   typedef logic [ROW_W-1:0] row_t;

   // DUT inputs
   logic      clk = 1'b0;
   logic      rst;
   logic      en;
   dim_t      oy;
   dim_t      iy;
   dim_t      ox;
   stride_t   s;
   stride_t   p;
   log2_t     ix_log2;
   logic      wr_en;
   mem_addr_t wr_addr;
   pix_t      wr_data;
   // DUT outputs
   row_t      re_row1_pixels;
   row_t      re_row2_pixels;
   row_t      re_row3_pixels;
   logic      done;

   // Host writes as seen by the memory
   pix_t   shadow [MEM_WORDS];
   integer seed = 32'hce72;
   // Config of the accepted fetch
   int     exp_oy;
   int     exp_s;
   int     exp_p;
   int     exp_iy;
   int     exp_ox;
   int     accepted_cnt = 0;
   int     done_cnt = 0;
   int     err_cnt = 0;
   int     check_cnt = 0;
   int     test_cnt = 0;
   int     test_err_base = 0;
   int     cycle_cnt = 0;
   row_t   last1;
   row_t   last2;
   row_t   last3;
   logic   done_seen;

   conv_datapath_front #(
      .PIXELS_IN_ROW (PIXELS_IN_ROW),
      .MEM_ADDR_W    (MEM_ADDR_W)
   ) UUT (
      .clk            (clk),
      .rst            (rst),
      .en             (en),
      .oy             (oy),
      .iy             (iy),
      .ox             (ox),
      .s              (s),
      .p              (p),
      .ix_log2        (ix_log2),
      .wr_en          (wr_en),
      .wr_addr        (wr_addr),
      .wr_data        (wr_data),
      .re_row1_pixels (re_row1_pixels),
      .re_row2_pixels (re_row2_pixels),
      .re_row3_pixels (re_row3_pixels),
      .done           (done)
   );

   always #2 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Expected row from the shadow image
   ////////////////////////////////////////////////////////////////////////////

   function automatic row_t ref_row(input int oy_v, input int s_v, input int p_v,
                                    input int iy_v, input int ox_v, input int i_v);
      row_t row;
      int   r;
      int   c;
      int   j;
      row = '0;
      // Input row for window row i
      r = oy_v * s_v - p_v + i_v;
      for (j = 0; j < PIXELS_IN_ROW; j++) begin
         c = j * s_v - p_v;
         // Zero outside the image or past ox
         if (r >= 0 && r < iy_v && c >= 0 && c < IMG_W && j < ox_v) begin
            row[j*8 +: 8] = shadow[(r << IX_LOG2) + c];
         end
      end
      return row;
   endfunction

   task automatic check_row(input int idx, input row_t got, input row_t exp);
      check_cnt++;
      assert (got === exp) else begin
         $display("mismatch at %0t: row %0d for oy %0d got %h expected %h",
                  $time, idx, exp_oy, got, exp);
         err_cnt++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Compare process
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (rst) begin
         // Outputs come out of reset as zero
         last1 = '0;
         last2 = '0;
         last3 = '0;
         done_seen = 1'b0;
      end else if (done) begin
         assert (!done_seen) else begin
            $display("done stayed high for more than one cycle at %0t", $time);
            err_cnt++;
         end
         check_row(1, re_row1_pixels, ref_row(exp_oy, exp_s, exp_p, exp_iy, exp_ox, 0));
         check_row(2, re_row2_pixels, ref_row(exp_oy, exp_s, exp_p, exp_iy, exp_ox, 1));
         check_row(3, re_row3_pixels, ref_row(exp_oy, exp_s, exp_p, exp_iy, exp_ox, 2));
         last1 = re_row1_pixels;
         last2 = re_row2_pixels;
         last3 = re_row3_pixels;
         done_cnt <= done_cnt + 1;
         done_seen = 1'b1;
      end else begin
         done_seen = 1'b0;
         // Rows hold between done pulses
         assert (re_row1_pixels === last1 && re_row2_pixels === last2 &&
                 re_row3_pixels === last3) else begin
            $display("row outputs changed without done at %0t", $time);
            err_cnt++;
         end
      end
   end

   // Hang guard
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("timeout waiting for done after %0d cycles", cycle_cnt);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic host_write(input int addr, input pix_t data);
      @(posedge clk);
      wr_en   <= 1'b1;
      wr_addr <= mem_addr_t'(addr);
      wr_data <= data;
      shadow[addr] = data;
   endtask

   task automatic host_idle();
      @(posedge clk);
      wr_en <= 1'b0;
   endtask

   // Every word holds data so a read that padding should skip shows up
   task automatic load_image();
      int a;
      for (a = 0; a < MEM_WORDS; a++) begin
         host_write(a, pix_t'($random(seed)));
      end
      host_idle();
   endtask

   // One-cycle en pulse and config recorded for the compare
   task automatic start_fetch(input int oy_v, input int s_v, input int p_v,
                              input int iy_v, input int ox_v);
      @(posedge clk);
      en <= 1'b1;
      oy <= dim_t'(oy_v);
      iy <= dim_t'(iy_v);
      ox <= dim_t'(ox_v);
      s  <= stride_t'(s_v);
      p  <= stride_t'(p_v);
      exp_oy = oy_v;
      exp_s  = s_v;
      exp_p  = p_v;
      exp_iy = iy_v;
      exp_ox = ox_v;
      accepted_cnt++;
      @(posedge clk);
      en <= 1'b0;
   endtask

   task automatic wait_done();
      do @(posedge clk); while (done !== 1'b1);
   endtask

   task automatic fetch(input int oy_v, input int s_v, input int p_v,
                        input int iy_v, input int ox_v);
      start_fetch(oy_v, s_v, p_v, iy_v, ox_v);
      wait_done();
   endtask

   task automatic finish_test(input string name);
      repeat (2) @(posedge clk);
      check_cnt++;
      assert (done_cnt == accepted_cnt) else begin
         $display("saw %0d done pulses for %0d accepted starts", done_cnt, accepted_cnt);
         err_cnt++;
      end
      test_cnt++;
      if (err_cnt == test_err_base) begin
         $display("test %0d %s: ok", test_cnt, name);
      end else begin
         $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
      end
      test_err_base = err_cnt;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      rst     <= 1'b1;
      en      <= 1'b0;
      oy      <= '0;
      iy      <= '0;
      ox      <= '0;
      s       <= '0;
      p       <= '0;
      ix_log2 <= log2_t'(IX_LOG2);
      wr_en   <= 1'b0;
      wr_addr <= '0;
      wr_data <= '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      load_image();

      // Rows copied straight from the image
      fetch(0, 1, 0, IMG_H, PIXELS_IN_ROW);
      fetch(3, 1, 0, IMG_H, PIXELS_IN_ROW);
      fetch(5, 1, 0, IMG_H, PIXELS_IN_ROW);
      finish_test("plain rows");

      // Top rows and left columns padded
      fetch(0, 2, 2, IMG_H, PIXELS_IN_ROW);
      fetch(1, 2, 2, IMG_H, PIXELS_IN_ROW);
      fetch(3, 2, 2, IMG_H, PIXELS_IN_ROW);
      finish_test("stride and padding");

      // Past the last row and past ox
      fetch(6, 1, 0, IMG_H, 5);
      fetch(4, 2, 1, IMG_H, 3);
      fetch(2, 1, 0, 3, PIXELS_IN_ROW);
      finish_test("bottom edge and short ox");

      // Host writes to rows 4..7 while rows 0..2 are fetched
      fork
         fetch(0, 1, 0, IMG_H, PIXELS_IN_ROW);
         begin
            repeat (24) begin
               host_write(64 + ($random(seed) & 63), pix_t'($random(seed)));
               if ($random(seed) & 1) begin
                  host_idle();
               end
            end
            host_idle();
         end
      join
      // Picks up the new values
      fetch(4, 1, 0, IMG_H, PIXELS_IN_ROW);
      finish_test("host contention");

      // Second en while busy with a different oy that must not be used
      start_fetch(1, 1, 0, IMG_H, PIXELS_IN_ROW);
      repeat (5) @(posedge clk);
      en <= 1'b1;
      oy <= dim_t'(5);
      @(posedge clk);
      en <= 1'b0;
      wait_done();
      // Quiet window with no extra done and no row change
      repeat (3 * PIXELS_IN_ROW + 10) @(posedge clk);
      finish_test("output stability");

      repeat (4) @(posedge clk);
      $display("tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule : conv_dp_front_tb

`default_nettype wire

//--- conv_mem_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Feature memory addressing and requester identity
////////////////////////////////////////////////////////////////////////////

package conv_mem_pkg;

   // Width of the SRAM address bus
   // The memory decodes only its low MEM_ADDR_W bits
   localparam int MEM_BUS_AW = 16;

   // Feature memory word address, row << ix_log2 plus column
   typedef logic [MEM_BUS_AW-1:0] mem_addr_t;

   // Requesters sharing the single SRAM port
   typedef enum logic {
      REQ_HOST  = 1'b0,
      REQ_FETCH = 1'b1
   } req_id_t;

endpackage : conv_mem_pkg

`default_nettype wire

//--- feature_mem.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Single-port synchronous feature SRAM
////////////////////////////////////////////////////////////////////////////

module feature_mem #(
   parameter int MEM_ADDR_W = 12
) (
   input  wire logic                    clk,
   input  wire logic                    mem_en,
   input  wire logic                    mem_we,
   input  wire conv_mem_pkg::mem_addr_t mem_addr,
   input  wire conv_cfg_pkg::pix_t      mem_wdata,
   output conv_cfg_pkg::pix_t           mem_rdata
);
   import conv_cfg_pkg::*;

   localparam int DEPTH = 1 << MEM_ADDR_W;

   // Storage array, contents come only from host writes
   pix_t ram [DEPTH];

   // Decoded word address
   logic [MEM_ADDR_W-1:0] word_addr;

   assign word_addr = mem_addr[MEM_ADDR_W-1:0];

   // Write or registered read, one access per cycle
   always_ff @(posedge clk) begin
      if (mem_en) begin
         if (mem_we) begin
            ram[word_addr] <= mem_wdata;
         end else begin
            // Data shows up the cycle after the access
            mem_rdata <= ram[word_addr];
         end
      end
   end

endmodule : feature_mem

`default_nettype wire

//--- mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Fixed-priority arbiter for the feature SRAM
// Host strobes always win, the row fetcher gets the idle cycles
////////////////////////////////////////////////////////////////////////////

module mem_arbiter (
   input  wire logic                    clk,
   input  wire logic                    rst,
   mem_port_if.arbiter                  host,
   mem_port_if.arbiter                  fetch,
   output logic                         mem_en,
   output logic                         mem_we,
   output conv_mem_pkg::mem_addr_t      mem_addr,
   output conv_cfg_pkg::pix_t           mem_wdata,
   input  wire conv_cfg_pkg::pix_t      mem_rdata
);
   import conv_mem_pkg::*;

   // Owner of last cycle's access, steers read data back
   req_id_t grant_q;

   // Grant is combinational
   assign host.gnt  = host.req;
   assign fetch.gnt = fetch.req & ~host.req;

   // SRAM port mux
   always_comb begin
      if (host.req) begin
         mem_en    = 1'b1;
         mem_we    = host.we;
         mem_addr  = host.addr;
         mem_wdata = host.wdata;
      end else begin
         mem_en    = fetch.req;
         mem_we    = fetch.we;
         mem_addr  = fetch.addr;
         mem_wdata = fetch.wdata;
      end
   end

   // Remember who was granted, the read returns a cycle later
   always_ff @(posedge clk) begin
      if (rst) begin
         grant_q <= REQ_HOST;
      end else if (host.req) begin
         grant_q <= REQ_HOST;
      end else if (fetch.req) begin
         grant_q <= REQ_FETCH;
      end
   end

   // Read data only to the port that issued it
   assign host.rdata  = (grant_q == REQ_HOST)  ? mem_rdata : '0;
   assign fetch.rdata = (grant_q == REQ_FETCH) ? mem_rdata : '0;

endmodule : mem_arbiter

`default_nettype wire

//--- mem_port_if.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// One requester's port onto the shared feature memory
////////////////////////////////////////////////////////////////////////////

interface mem_port_if;
   import conv_cfg_pkg::*;
   import conv_mem_pkg::*;

   // Request side
   logic      req;
   logic      we;
   mem_addr_t addr;
   pix_t      wdata;

   // Arbiter side
   // Request accepted when req and gnt are both high
   logic      gnt;
   // Read data, valid one cycle after the accepted read
   pix_t      rdata;

   modport requester (
      output req, we, addr, wdata,
      input  gnt, rdata
   );

   modport arbiter (
      input  req, we, addr, wdata,
      output gnt, rdata
   );

endinterface : mem_port_if

`default_nettype wire

//--- row_buffers.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Row buffers
// Staging copy filled pixel by pixel, output copy updated on swap
////////////////////////////////////////////////////////////////////////////

module row_buffers #(
   parameter int  PIXELS_IN_ROW = 8,
   localparam int COL_W         = (PIXELS_IN_ROW > 1) ? $clog2(PIXELS_IN_ROW) : 1
) (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    pix_wr,
   input  wire logic [1:0]              pix_row,
   input  wire logic [COL_W-1:0]        pix_col,
   input  wire conv_cfg_pkg::pix_t      pix_data,
   input  wire logic                    swap,
   output logic [PIXELS_IN_ROW*8-1:0]   re_row1_pixels,
   output logic [PIXELS_IN_ROW*8-1:0]   re_row2_pixels,
   output logic [PIXELS_IN_ROW*8-1:0]   re_row3_pixels
);
   import conv_cfg_pkg::*;

   // One row, pixel 0 in the low byte
   typedef pix_t [PIXELS_IN_ROW-1:0] row_t;

   row_t stage [3];
   row_t out_q [3];

   // Staging write, row index 3 never used
   always_ff @(posedge clk) begin
      if (pix_wr && pix_row != 2'd3) begin
         stage[pix_row][pix_col] <= pix_data;
      end
   end

   // Output copy
   // Holds between fetches so the multiply stage sees stable rows
   always_ff @(posedge clk) begin
      if (rst) begin
         out_q <= '{default: '0};
      end else if (swap) begin
         out_q <= stage;
      end
   end

   // Flattened row buses
   assign re_row1_pixels = out_q[0];
   assign re_row2_pixels = out_q[1];
   assign re_row3_pixels = out_q[2];

endmodule : row_buffers

`default_nettype wire

//--- row_fetcher.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Row fetcher
// Walks three padded input rows for one output row
// Pixel j of row i comes from input[oy*s - p + i][j*s - p]
////////////////////////////////////////////////////////////////////////////

module row_fetcher #(
   parameter int  PIXELS_IN_ROW = 8,
   localparam int COL_W         = (PIXELS_IN_ROW > 1) ? $clog2(PIXELS_IN_ROW) : 1
) (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    en,
   input  wire conv_cfg_pkg::dim_t      oy,
   input  wire conv_cfg_pkg::dim_t      iy,
   input  wire conv_cfg_pkg::dim_t      ox,
   input  wire conv_cfg_pkg::stride_t   s,
   input  wire conv_cfg_pkg::stride_t   p,
   input  wire conv_cfg_pkg::log2_t     ix_log2,
   mem_port_if.requester                mem,
   output logic                         pix_wr,
   output logic [1:0]                   pix_row,
   output logic [COL_W-1:0]             pix_col,
   output conv_cfg_pkg::pix_t           pix_data,
   output logic                         swap,
   output logic                         done
);
   import conv_cfg_pkg::*;
   import conv_mem_pkg::*;

   localparam logic [COL_W-1:0] LAST_COL = COL_W'(PIXELS_IN_ROW - 1);

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DRAIN,
      SWAP
   } state_t;

   state_t state;

   // Latched configuration
   dim_t    oy_q;
   dim_t    iy_q;
   dim_t    ox_q;
   stride_t s_q;
   stride_t p_q;
   log2_t   ix_log2_q;

   // Window position, i over rows and j over output pixels
   logic [1:0]       row_idx;
   logic [COL_W-1:0] col_idx;

   // Input position of the current pixel
   dim_t cur_row;
   dim_t cur_col;
   dim_t row_base;
   logic pad;
   logic step;
   logic last_pix;

   // One-deep tag for the pixel issued last cycle
   logic             tag_vld;
   logic             tag_pad;
   logic [1:0]       tag_row;
   logic [COL_W-1:0] tag_col;

   ////////////////////////////////////////////////////////////////////////////
   // Position and padding
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      cur_row  = oy_q * dim_t'(s_q) - dim_t'(p_q) + dim_t'(row_idx);
      cur_col  = dim_t'(col_idx) * dim_t'(s_q) - dim_t'(p_q);
      // Arithmetic shift is nonzero for negative or too wide columns
      pad      = (cur_row < 0) || (cur_row >= iy_q) ||
                 ((cur_col >>> ix_log2_q) != 0) ||
                 (dim_t'(col_idx) >= ox_q);
      row_base = cur_row <<< ix_log2_q;
   end

   // Padded pixels advance alone, real ones wait for the grant
   assign step     = (state == RUN) && (pad || mem.gnt);
   assign last_pix = (row_idx == 2'd2) && (col_idx == LAST_COL);

   // Read request, held with a stable address until granted
   assign mem.req   = (state == RUN) && !pad;
   assign mem.we    = 1'b0;
   assign mem.wdata = '0;
   assign mem.addr  = mem_addr_t'(row_base + cur_col);

   ////////////////////////////////////////////////////////////////////////////
   // FSM and counters
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= IDLE;
         row_idx <= '0;
         col_idx <= '0;
         tag_vld <= 1'b0;
         done    <= 1'b0;
      end else begin
         tag_vld <= step;
         // Rows reach the outputs the cycle after swap
         done    <= (state == SWAP);
         case (state)
            IDLE: begin
               if (en) begin
                  state   <= RUN;
                  row_idx <= '0;
                  col_idx <= '0;
               end
            end
            RUN: begin
               if (step) begin
                  if (last_pix) begin
                     state <= DRAIN;
                  end else if (col_idx == LAST_COL) begin
                     col_idx <= '0;
                     row_idx <= row_idx + 2'd1;
                  end else begin
                     col_idx <= col_idx + 1'b1;
                  end
               end
            end
            // Last pixel lands in staging here
            DRAIN: state <= SWAP;
            SWAP:  state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // Config only taken at start, en while busy is dropped
   always_ff @(posedge clk) begin
      if (state == IDLE && en) begin
         oy_q      <= oy;
         iy_q      <= iy;
         ox_q      <= ox;
         s_q       <= s;
         p_q       <= p;
         ix_log2_q <= ix_log2;
      end
   end

   // Destination of the pixel in flight
   always_ff @(posedge clk) begin
      if (step) begin
         tag_pad <= pad;
         tag_row <= row_idx;
         tag_col <= col_idx;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Staging write port
   ////////////////////////////////////////////////////////////////////////////

   // Read data returns together with its tag
   assign pix_wr   = tag_vld;
   assign pix_row  = tag_row;
   assign pix_col  = tag_col;
   assign pix_data = tag_pad ? '0 : mem.rdata;
   assign swap     = (state == SWAP);

endmodule : row_fetcher

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the convolution front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f all.f --top-module conv_dp_front_tb -o conv_dp_front_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/conv_dp_front_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# Result decided by the testbench's own summary line
if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
   exit 0
fi
exit 1
